// File: logic/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

  // bus pacing
  localparam int SCL_QUARTER = 4;       // sys clocks per quarter bit
  localparam int TICK_W      = $clog2(SCL_QUARTER + 1);

  // command queue
  localparam int FIFO_DEPTH  = 4;
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

  // 2 KB part, top three address bits ride in the control byte
  localparam logic [3:0] DEV_CODE = 4'b1010;
  localparam int ADDR_W = 11;

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } eeprom_op_e;

  // one-hot engine states
  typedef enum logic [8:0] {
    IDLE    = 9'b0_0000_0001,
    START   = 9'b0_0000_0010,
    CTRL_W  = 9'b0_0000_0100,
    ADDR_WR = 9'b0_0000_1000,   // address byte
    DATA_W  = 9'b0_0001_0000,
    RESTART = 9'b0_0010_0000,
    CTRL_R  = 9'b0_0100_0000,
    DATA_R  = 9'b0_1000_0000,
    STOP    = 9'b1_0000_0000
  } xfer_state_e;

  typedef struct packed {
    eeprom_op_e        op;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
  } eeprom_cmd_t;

  typedef struct packed {
    eeprom_op_e        op;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        rdata;   // zero on writes
    logic              ack_err;
  } eeprom_rsp_t;

endpackage

`default_nettype wire

// File: logic/eeprom_req_decode.sv
`default_nettype none

module eeprom_req_decode
  import eeprom_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr,
  input  logic              rd,
  input  logic [ADDR_W-1:0] addr,
  input  logic [7:0]        wdata,
  output logic              push,
  output eeprom_cmd_t       cmd,
  output logic              req_err
);

  logic one_req;

  // exactly one strobe is a valid request
  assign one_req = wr ^ rd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      push    <= 1'b0;
      req_err <= 1'b0;
    end else begin
      push    <= one_req;
      req_err <= wr & rd;   // no priority between the two
    end
  end

  always_ff @(posedge clk) begin
    if (one_req) begin
      cmd.op    <= rd ? OP_READ : OP_WRITE;
      cmd.addr  <= addr;
      cmd.wdata <= wdata;
    end
  end

  // a request is either queued or rejected, never both
  a_push_or_err: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(push && req_err)
  );

endmodule

`default_nettype wire

// File: logic/eeprom_cmd_fifo.sv
`default_nettype none

module eeprom_cmd_fifo
  import eeprom_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        push,
  input  eeprom_cmd_t cmd_in,
  input  logic        pop,
  output eeprom_cmd_t head,
  output logic        not_empty,
  output logic        drop
);

  eeprom_cmd_t           mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wptr;
  logic [FIFO_PTR_W-1:0] rptr;
  logic [FIFO_PTR_W:0]   count;
  logic                  full;
  logic                  wr_en;

  assign full      = count == (FIFO_PTR_W + 1)'(FIFO_DEPTH);
  assign not_empty = count != '0;
  assign head      = mem[rptr];

  // a pop frees the slot in the same cycle
  assign wr_en = push && (!full || pop);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
      drop  <= 1'b0;
    end else begin
      drop <= push && full && !pop;
      if (wr_en)
        wptr <= wptr + 1'b1;
      if (pop)
        rptr <= rptr + 1'b1;
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wptr] <= cmd_in;
  end

  // engine only pops what it can see
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> not_empty
  );

endmodule

`default_nettype wire

// File: logic/scl_phase_timer.sv
`default_nettype none

module scl_phase_timer
  import eeprom_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic tick
);

  logic [TICK_W-1:0] cnt;
  logic              wrap;

  assign wrap = cnt == TICK_W'(SCL_QUARTER - 1);

  // held at zero between transfers so the first quarter is full length
  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      cnt <= '0;
    end else if (wrap) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign tick = run && wrap;

endmodule

`default_nettype wire

// File: logic/eeprom_xfer_engine.sv
`default_nettype none

module eeprom_xfer_engine
  import eeprom_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tick,
  input  eeprom_cmd_t head,
  input  logic        not_empty,
  input  logic        sda_in,
  output logic        pop,
  output logic        run,
  output logic        scl,
  output logic        sda_pull,
  output logic        done,
  output eeprom_rsp_t rsp
);

  xfer_state_e state;
  xfer_state_e nxt_state;
  eeprom_cmd_t cur;
  logic [1:0]  phase;      // quarter of the current bit
  logic [2:0]  bitcnt;
  logic        ack_slot;   // ninth bit of a byte
  logic [7:0]  shreg;
  logic [7:0]  nxt_byte;
  logic [7:0]  rdata;
  logic        ack_err;
  logic        in_byte;
  logic        tx_byte;
  logic        seg_end;

  assign pop = (state == IDLE) && not_empty;
  assign run = state != IDLE;

  assign in_byte = state inside {CTRL_W, ADDR_WR, DATA_W, CTRL_R, DATA_R};
  assign tx_byte = in_byte && (state != DATA_R);

  // last quarter of a start/stop or of a byte's ack slot
  assign seg_end = tick && (phase == 2'd3) && (!in_byte || ack_slot);

  always_comb begin
    nxt_state = state;
    nxt_byte  = shreg;
    case (state)
      START: begin
        nxt_state = CTRL_W;
        nxt_byte  = {DEV_CODE, cur.addr[ADDR_W-1:8], 1'b0};
      end
      CTRL_W: begin
        nxt_state = ADDR_WR;
        nxt_byte  = cur.addr[7:0];
      end
      ADDR_WR: begin
        nxt_state = (cur.op == OP_READ) ? RESTART : DATA_W;
        nxt_byte  = cur.wdata;
      end
      DATA_W:  nxt_state = STOP;
      RESTART: begin
        nxt_state = CTRL_R;
        nxt_byte  = {DEV_CODE, cur.addr[ADDR_W-1:8], 1'b1};
      end
      CTRL_R:  nxt_state = DATA_R;
      DATA_R:  nxt_state = STOP;
      STOP:    nxt_state = IDLE;
      default: nxt_state = IDLE;
    endcase
    // slave refused a byte, abandon the rest
    if (in_byte && ack_err)
      nxt_state = STOP;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      phase    <= 2'd0;
      bitcnt   <= 3'd7;
      ack_slot <= 1'b0;
      scl      <= 1'b1;
      sda_pull <= 1'b0;
      done     <= 1'b0;
      ack_err  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (pop) begin
        state   <= START;
        ack_err <= 1'b0;
      end else if (tick) begin
        phase <= phase + 2'd1;
        case (phase)
          2'd0: begin
            // ack slots and the whole read byte leave the line released,
            // which also gives the master nack after the read byte
            sda_pull <= (state == STOP) || (tx_byte && !ack_slot && !shreg[7]);
          end
          2'd1: scl <= 1'b1;
          2'd2: begin
            if (state inside {START, RESTART})
              sda_pull <= 1'b1;          // falls with scl high
            else if (state == STOP)
              sda_pull <= 1'b0;          // rises with scl high
            else if (tx_byte && ack_slot)
              ack_err <= ack_err | sda_in;
          end
          default: begin
            if (state != STOP)
              scl <= 1'b0;               // bus left idle high after stop
            if (seg_end) begin
              state    <= nxt_state;
              bitcnt   <= 3'd7;
              ack_slot <= 1'b0;
              done     <= state == STOP;
            end else if (in_byte) begin
              if (bitcnt == 3'd0)
                ack_slot <= 1'b1;
              else
                bitcnt <= bitcnt - 3'd1;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      cur   <= head;
      rdata <= '0;
    end
    if (seg_end) begin
      shreg <= nxt_byte;
      if (state == DATA_R)
        rdata <= shreg;
    end else if (tick && in_byte && !ack_slot) begin
      if (phase == 2'd2 && state == DATA_R)
        shreg <= {shreg[6:0], sda_in};   // msb first
      else if (phase == 2'd3 && tx_byte)
        shreg <= {shreg[6:0], 1'b0};
    end
  end

  assign rsp = '{op: cur.op, addr: cur.addr, rdata: rdata, ack_err: ack_err};

  a_scl_on_tick: assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(scl) |-> $past(tick)
  );

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |=> !done
  );

  // only start, restart and stop may move the data line under a high clock
  a_sda_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (scl && $past(scl) && !($past(state) inside {START, RESTART, STOP}))
      |-> $stable(sda_pull)
  );

endmodule

`default_nettype wire

// File: logic/eeprom_ctrl_top.sv
`default_nettype none

module eeprom_ctrl_top
  import eeprom_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr,
  input  logic              rd,
  input  logic [ADDR_W-1:0] addr,
  input  logic [7:0]        wdata,
  input  logic              sda_in,
  output logic              scl,
  output logic              sda_pull,   // open drain, high pulls sda low
  output logic              done,
  output eeprom_rsp_t       rsp,
  output logic              req_err,
  output logic              drop
);

  logic        push;
  eeprom_cmd_t cmd;
  eeprom_cmd_t head;
  logic        not_empty;
  logic        pop;
  logic        run;
  logic        tick;

  eeprom_req_decode u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .rd      (rd),
    .addr    (addr),
    .wdata   (wdata),
    .push    (push),
    .cmd     (cmd),
    .req_err (req_err)
  );

  eeprom_cmd_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .cmd_in    (cmd),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .drop      (drop)
  );

  scl_phase_timer u_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .tick  (tick)
  );

  eeprom_xfer_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .tick      (tick),
    .head      (head),
    .not_empty (not_empty),
    .sda_in    (sda_in),
    .pop       (pop),
    .run       (run),
    .scl       (scl),
    .sda_pull  (sda_pull),
    .done      (done),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

// File: bench/eeprom_slave_model.sv
`default_nettype none

module eeprom_slave_model
  import eeprom_pkg::*;
(
  input  logic scl,
  input  logic sda,
  input  logic nack_mode,   // refuse the address byte
  output logic pull
);

  logic [7:0]        mem [2048];
  logic [ADDR_W-1:0] ptr;
  logic [7:0]        sr;
  logic [7:0]        txbyte;
  logic              scl_q;
  logic              sda_q;
  logic              active;
  logic              ack_phase;
  logic              acked;
  logic              tx;
  logic              tx_next;
  int                bitcnt;
  int                byte_idx;

  initial begin
    for (int i = 0; i < 2048; i++)
      mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5c;   // every address bit matters
    pull      = 1'b0;
    active    = 1'b0;
    ack_phase = 1'b0;
    acked     = 1'b0;
    tx        = 1'b0;
    tx_next   = 1'b0;
    bitcnt    = 0;
    byte_idx  = 0;
    ptr       = '0;
    sr        = '0;
    txbyte    = '0;
  end

  always @(scl or sda) begin
    if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
      active    = 1'b1;   // start or repeated start
      ack_phase = 1'b0;
      tx        = 1'b0;
      tx_next   = 1'b0;
      bitcnt    = 0;
      byte_idx  = 0;
      pull      = 1'b0;
    end else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
      active = 1'b0;      // stop
      pull   = 1'b0;
    end else if (active && scl_q === 1'b0 && scl === 1'b1) begin
      if (!ack_phase) begin
        if (!tx)
          sr = {sr[6:0], sda};
        bitcnt++;
      end
    end else if (active && scl_q === 1'b1 && scl === 1'b0) begin
      if (ack_phase) begin
        ack_phase = 1'b0;
        bitcnt    = 0;
        pull      = 1'b0;
        if (!acked || tx) begin
          active = 1'b0;  // refused byte or read byte finished
        end else if (tx_next) begin
          tx   = 1'b1;
          pull = !txbyte[7];
        end
      end else if (bitcnt == 8) begin
        ack_phase = 1'b1;
        if (tx) begin
          pull = 1'b0;    // master answers this slot
        end else begin
          acked = 1'b1;
          if (byte_idx == 0) begin
            if (sr[7:4] != DEV_CODE) begin
              acked = 1'b0;
              $display("slave: control byte %h has a wrong device code", sr);
            end else if (sr[0]) begin
              tx_next = 1'b1;
              txbyte  = mem[{sr[3:1], ptr[7:0]}];
            end else begin
              ptr[10:8] = sr[3:1];
            end
          end else if (byte_idx == 1) begin
            if (nack_mode)
              acked = 1'b0;
            else
              ptr[7:0] = sr;
          end else begin
            mem[ptr] = sr;
          end
          byte_idx++;
          pull = acked;
        end
      end else if (tx) begin
        pull = !txbyte[7 - bitcnt];
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule

`default_nettype wire

// File: bench/eeprom_ctrl_tb.sv
`default_nettype none

module eeprom_ctrl_tb
  import eeprom_pkg::*;
();

  // a read is start, 18 slots, restart, 18 slots, stop
  localparam int READ_CLKS = 39 * 4 * SCL_QUARTER;
  localparam int MAX_CMDS  = 48;
  localparam int LIMIT     = MAX_CMDS * (READ_CLKS + 8) + 400;

  logic              clk;
  logic              rst_n;
  logic              wr;
  logic              rd;
  logic [ADDR_W-1:0] addr;
  logic [7:0]        wdata;
  logic              nack_mode;
  logic              scl;
  logic              sda;
  logic              sda_pull;
  logic              slave_pull;
  logic              done;
  logic              req_err;
  logic              drop;
  eeprom_rsp_t       rsp;

  logic [7:0]  ref_mem [2048];
  eeprom_rsp_t exp_q[$];
  int          stamp_q[$];     // issue cycle of each expected response
  eeprom_rsp_t exp_head;
  logic        exp_valid;
  logic        pop_pending;
  logic        allow_drop;
  logic [31:0] lfsr;
  int          cyc = 0;
  int          errors = 0;
  int          dones = 0;
  int          drops = 0;
  int          req_errs = 0;
  int          tests = 0;
  int          passed = 0;

  assign sda = !(sda_pull || slave_pull);   // wired and of both pull-downs

  eeprom_ctrl_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .rd       (rd),
    .addr     (addr),
    .wdata    (wdata),
    .sda_in   (sda),
    .scl      (scl),
    .sda_pull (sda_pull),
    .done     (done),
    .rsp      (rsp),
    .req_err  (req_err),
    .drop     (drop)
  );

  eeprom_slave_model u_slave (
    .scl       (scl),
    .sda       (sda),
    .nack_mode (nack_mode),
    .pull      (slave_pull)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > LIMIT) begin
      $display("timeout after %0d cycles with %0d responses outstanding", cyc, exp_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // the dropped request is the one strobed two cycles earlier
  function automatic void drop_request(input int stamp);
    for (int i = exp_q.size() - 1; i >= 0; i--) begin
      if (stamp_q[i] == stamp) begin
        exp_q.delete(i);
        stamp_q.delete(i);
        return;
      end
    end
    errors++;
    $display("drop at %0t matches no request strobed two cycles earlier", $time);
  endfunction

  task automatic strobe(input eeprom_op_e op, input logic [ADDR_W-1:0] a,
                        input logic [7:0] d, input logic nak);
    eeprom_rsp_t e;
    e.op      = op;
    e.addr    = a;
    e.ack_err = nak;
    e.rdata   = (op == OP_READ && !nak) ? ref_mem[a] : 8'h00;
    if (op == OP_WRITE && !nak)
      ref_mem[a] = d;
    wr    = (op == OP_WRITE);
    rd    = (op == OP_READ);
    addr  = a;
    wdata = d;
    exp_q.push_back(e);
    stamp_q.push_back(cyc);
    @(negedge clk);
    wr = 1'b0;
    rd = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || pop_pending)
      @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, errors - err_before);
    end
  endtask

  always @(negedge clk) begin
    if (done) begin
      dones++;
      pop_pending = 1'b1;
    end else if (pop_pending) begin
      void'(exp_q.pop_front());
      void'(stamp_q.pop_front());
      pop_pending = 1'b0;
    end
    if (req_err)
      req_errs++;
    if (drop) begin
      drops++;
      drop_request(cyc - 2);
    end
    exp_valid = exp_q.size() != 0;
    exp_head  = exp_valid ? exp_q[0] : '0;
  end

  a_done_expected: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> exp_valid)
    else begin
      errors++;
      $display("done pulse at %0t with no command outstanding", $time);
    end

  a_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    (done && exp_valid) |-> rsp == exp_head)
    else begin
      errors++;
      $display("Mismatch at %0t: rsp expected %h got %h", $time, exp_head, rsp);
    end

  a_idle_bus: assert property (@(posedge clk) disable iff (!rst_n)
    (uut.u_engine.state == IDLE) |-> (scl && !sda_pull))
    else begin
      errors++;
      $display("bus not released while the engine is idle, time %0t", $time);
    end

  a_req_err: assert property (@(posedge clk) disable iff (!rst_n)
    (wr && rd) |=> req_err)
    else begin
      errors++;
      $display("req_err missing after conflicting strobes at %0t", $time);
    end

  a_req_err_cause: assert property (@(posedge clk) disable iff (!rst_n)
    req_err |-> $past(wr && rd))
    else begin
      errors++;
      $display("req_err raised without conflicting strobes at %0t", $time);
    end

  a_drop_allowed: assert property (@(posedge clk) disable iff (!rst_n)
    drop |-> allow_drop)
    else begin
      errors++;
      $display("drop raised outside the overflow test at %0t", $time);
    end

  initial begin
    logic [ADDR_W-1:0] a;
    logic [7:0]        d;
    int                e0;
    int                d0;
    int                p0;
    int                r0;
    int                strobes;
    clk         = 1'b0;
    rst_n       = 1'b0;
    wr          = 1'b0;
    rd          = 1'b0;
    addr        = '0;
    wdata       = '0;
    nack_mode   = 1'b0;
    lfsr        = 32'heb2a;
    pop_pending = 1'b0;
    allow_drop  = 1'b0;
    exp_valid   = 1'b0;
    exp_head    = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 2048; i++)
      ref_mem[i] = u_slave.mem[i];

    e0 = errors;
    a  = ADDR_W'(rand_bits(ADDR_W));
    d  = 8'(rand_bits(8));
    strobe(OP_WRITE, a, d, 1'b0);
    strobe(OP_READ, a, 8'h00, 1'b0);
    drain();
    finish_test("write then read back", e0);

    e0 = errors;
    a  = ADDR_W'(rand_bits(ADDR_W));
    for (int b = 0; b < 8; b++) begin
      strobe(OP_WRITE, {3'(b), a[7:0]}, {5'(rand_bits(5)), 3'(b)}, 1'b0);  // distinct low bits
      drain();
    end
    for (int b = 0; b < 8; b++) begin
      strobe(OP_READ, {3'(b), a[7:0]}, 8'h00, 1'b0);
      drain();
    end
    finish_test("block bits", e0);

    e0 = errors;
    a  = ADDR_W'(rand_bits(ADDR_W));
    strobe(OP_WRITE, a, 8'(rand_bits(8)), 1'b0);
    strobe(OP_READ, a, 8'h00, 1'b0);
    strobe(OP_WRITE, a ^ 11'h4a5, 8'(rand_bits(8)), 1'b0);
    strobe(OP_READ, a ^ 11'h4a5, 8'h00, 1'b0);
    drain();
    finish_test("queued commands", e0);

    e0         = errors;
    allow_drop = 1'b1;
    d0         = dones;
    p0         = drops;
    strobes    = 0;
    while (!drop && strobes < 12) begin   // drop is steady at the falling edge
      strobe(OP_READ, ADDR_W'(rand_bits(ADDR_W)), 8'h00, 1'b0);
      strobes++;
    end
    drain();
    assert (drops != p0 && dones - d0 == strobes - (drops - p0))
      else begin
        errors++;
        $display("overflow: %0d strobes, %0d drops, %0d done pulses do not add up",
                 strobes, drops - p0, dones - d0);
      end
    allow_drop = 1'b0;
    finish_test("overflow", e0);

    e0        = errors;
    a         = ADDR_W'(rand_bits(ADDR_W));
    nack_mode = 1'b1;
    strobe(OP_WRITE, a, ~ref_mem[a], 1'b1);
    drain();
    assert (u_slave.mem[a] == ref_mem[a])
      else begin
        errors++;
        $display("slave memory changed by a refused write at address %h", a);
      end
    nack_mode = 1'b0;
    strobe(OP_READ, a, 8'h00, 1'b0);
    drain();
    finish_test("acknowledge error", e0);

    e0    = errors;
    r0    = req_errs;
    wr    = 1'b1;
    rd    = 1'b1;
    addr  = ADDR_W'(rand_bits(ADDR_W));
    wdata = 8'(rand_bits(8));
    @(negedge clk);
    wr = 1'b0;
    rd = 1'b0;
    repeat (READ_CLKS + 4 * SCL_QUARTER) @(negedge clk);   // a stray read would finish by now
    assert (req_errs - r0 == 1)
      else begin
        errors++;
        $display("req_err pulsed %0d times for one conflicting request", req_errs - r0);
      end
    finish_test("conflicting request", e0);

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests, passed, tests - passed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
logic/eeprom_pkg.sv
logic/eeprom_req_decode.sv
logic/eeprom_cmd_fifo.sv
logic/scl_phase_timer.sv
logic/eeprom_xfer_engine.sv
logic/eeprom_ctrl_top.sv
bench/eeprom_slave_model.sv
bench/eeprom_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module eeprom_ctrl_tb -f src.f -o eeprom_tb \
  && ./obj_dir/eeprom_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
